//--- flist.f
src/lease_cache_pkg.sv
src/line_store.sv
src/lease_policy.sv
src/lease_table_loader.sv
src/miss_handler.sv
src/mem_arbiter.sv
src/lease_cache_top.sv
verification/mem_model.sv
verification/lease_cache_tb.sv

//--- verification/lease_cache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lease_cache_tb import lease_cache_pkg::*; ();

	localparam int                LINES    = 4;
	localparam int                TIMEOUT  = 1000;       // cycles per wait
	localparam int                P0_COUNT = 3;
	localparam int                P1_COUNT = 2;
	localparam logic [ADDR_W-1:0] BLK_A    = 16'h0100;
	localparam logic [ADDR_W-1:0] BYP0     = 16'h0240;   // lease 0 in phase 0
	localparam logic [ADDR_W-1:0] BYP1     = 16'h0380;   // lease 0 only in phase 1

	logic              clock;
	logic              resetn;
	logic [7:0]        phase;
	logic              core_req;
	core_req_t         core_cmd;
	logic              core_ack;
	logic [WORD_W-1:0] core_rdata;
	logic              mem_req;
	mem_cmd_t          mem_cmd;
	logic              mem_ack;
	logic [WORD_W-1:0] mem_rdata;
	int                txn_count;
	logic [WORD_W-1:0] ref_mem [2**ADDR_W];    // expected memory image
	string             test_name;
	int                tests;
	int                checks;
	int                test_checks;
	int                test_fails;
	int                fail_count;

	lease_cache_top #(.LINES(LINES), .DEFAULT_LEASE(8'd4)) uut (
		.clock_i      (clock),
		.resetn_i     (resetn),
		.phase_i      (phase),
		.core_req_i   (core_req),
		.core_cmd_i   (core_cmd),
		.core_ack_o   (core_ack),
		.core_rdata_o (core_rdata),
		.mem_req_o    (mem_req),
		.mem_cmd_o    (mem_cmd),
		.mem_ack_i    (mem_ack),
		.mem_rdata_i  (mem_rdata)
	);

	mem_model #(
		.P0_COUNT (P0_COUNT),
		.P1_COUNT (P1_COUNT),
		.BYP0_TAG (BYP0[ADDR_W-1:OFFSET_W]),
		.BYP1_TAG (BYP1[ADDR_W-1:OFFSET_W])
	) u_mem (
		.clock_i     (clock),
		.resetn_i    (resetn),
		.req_i       (mem_req),
		.cmd_i       (mem_cmd),
		.ack_o       (mem_ack),
		.rdata_o     (mem_rdata),
		.txn_count_o (txn_count)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// cache holds ack for as long as the core holds req
	assert property (@(posedge clock) disable iff (!resetn) core_ack && core_req |=> core_ack)
		else begin
			$display("core ack dropped while the core still held req in test %s", test_name);
			fail_count++;
		end

	// helpers
	// --------------------------------------------------
	function automatic logic [WORD_W-1:0] image_word(input logic [ADDR_W-1:0] addr);
		return {addr ^ 16'hC35A, addr};   // initial memory contents
	endfunction

	task automatic abort_run(input string reason);
		$display("timeout in test %s: %s", test_name, reason);
		$display("Checks failed");
		$finish;
	endtask

	task automatic check_value(input string what, input logic [WORD_W-1:0] exp,
	                           input logic [WORD_W-1:0] got);
		checks++;
		test_checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, got);
			test_fails++;
			fail_count++;
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = 0;
		test_fails  = 0;
		tests++;
	endtask

	task automatic finish_test();
		if (test_fails == 0)
			$display("test %s: ok (%0d checks)", test_name, test_checks);
		else
			$display("test %s: FAIL (%0d of %0d)", test_name, test_fails, test_checks);
	endtask

	task automatic wait_loading_done();
		int n;
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (uut.loading && n < TIMEOUT);
		if (uut.loading)
			abort_run("lease table reload never finished");
	endtask

	task automatic wait_mem_req();
		int n;
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (!mem_req && n < TIMEOUT);
		if (!mem_req)
			abort_run("no memory request appeared");
	endtask

	// one full four-phase core transfer, lat counts edges after the one that saw req
	task automatic core_access(input logic rw, input logic [ADDR_W-1:0] addr,
	                           input logic [WORD_W-1:0] wdata,
	                           output logic [WORD_W-1:0] rdata, output int lat);
		int n;
		@(posedge clock);
		core_req <= 1'b1;
		core_cmd <= '{rw: rw, addr: addr, wdata: wdata};
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (!core_ack && n < TIMEOUT);
		if (!core_ack)
			abort_run("core ack never came");
		rdata    = core_rdata;
		lat      = n - 1;
		core_req <= 1'b0;
		n = 0;
		do begin
			@(posedge clock);
			n++;
		end while (core_ack && n < TIMEOUT);
		if (core_ack)
			abort_run("core ack stayed high after req dropped");
	endtask

	task automatic load_and_check(input logic [ADDR_W-1:0] addr, output int lat);
		logic [WORD_W-1:0] rdata;
		core_access(1'b0, addr, '0, rdata, lat);
		check_value($sformatf("load %h", addr), ref_mem[addr], rdata);
	endtask

	task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
		logic [WORD_W-1:0] rdata;
		int                lat;
		core_access(1'b1, addr, data, rdata, lat);
		ref_mem[addr] = data;
	endtask

	// stimulus
	// --------------------------------------------------
	initial begin
		int lat;
		int base;
		tests      = 0;
		checks     = 0;
		fail_count = 0;
		test_name  = "reset";
		resetn     = 1'b0;
		phase      = 8'd0;
		core_req   = 1'b0;
		core_cmd   = '0;
		for (int a = 0; a < 2**ADDR_W; a++)
			ref_mem[a] = image_word(ADDR_W'(a));
		repeat (2) @(posedge clock);
		resetn <= 1'b1;

		start_test("reload");
		wait_loading_done();
		check_value("table reads", 1 + P0_COUNT, txn_count);   // header plus entries
		load_and_check(BLK_A, lat);
		finish_test();

		start_test("hit");
		base = txn_count;
		load_and_check(BLK_A + 2, lat);
		check_value("memory transactions", 0, txn_count - base);
		check_value("ack latency", 2, lat);
		finish_test();

		start_test("write-back");
		store_word(BLK_A + 1, 32'h5EED_0071);
		check_value("memory before eviction", image_word(BLK_A + 1), u_mem.mem_q[BLK_A + 1]);
		for (int i = 1; i <= LINES; i++)        // last one finds all leases live
			load_and_check(BLK_A + ADDR_W'(i * WORDS_PER_BLOCK), lat);
		check_value("memory after eviction", ref_mem[BLK_A + 1], u_mem.mem_q[BLK_A + 1]);
		load_and_check(BLK_A + 1, lat);
		finish_test();

		start_test("bypass");
		for (int i = 0; i < 3; i++) begin
			base = txn_count;
			load_and_check(BYP0 + ADDR_W'(i & 1), lat);
			check_value("transactions per bypass load", 1, txn_count - base);
		end
		base = txn_count;
		store_word(BYP0 + 2, 32'hB1A5_0002);
		check_value("transactions per bypass store", 1, txn_count - base);
		check_value("memory after bypass store", ref_mem[BYP0 + 2], u_mem.mem_q[BYP0 + 2]);
		finish_test();

		start_test("phase change");
		base = txn_count;
		@(posedge clock);
		phase <= 8'd1;
		wait_mem_req();
		check_value("header address", TABLE_BASE + TABLE_STRIDE, mem_cmd.addr);
		wait_loading_done();
		check_value("table reads", 1 + P1_COUNT, txn_count - base);
		for (int i = 0; i < 2; i++) begin
			base = txn_count;
			load_and_check(BYP1 + ADDR_W'(i), lat);
			check_value("transactions per bypass load", 1, txn_count - base);
		end
		finish_test();

		$display("%0d tests, %0d checks, %0d failures", tests, checks, fail_count);
		if (fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module mem_model import lease_cache_pkg::*; #(
	parameter int               P0_COUNT = 3,
	parameter int               P1_COUNT = 2,
	parameter logic [TAG_W-1:0] BYP0_TAG = '0,   // lease 0 in phase 0
	parameter logic [TAG_W-1:0] BYP1_TAG = '0    // lease 0 from phase 1 on
) (
	input  wire               clock_i,
	input  wire               resetn_i,
	input  wire               req_i,
	input  wire mem_cmd_t     cmd_i,
	output logic              ack_o,
	output logic [WORD_W-1:0] rdata_o,
	output int                txn_count_o
);

	logic [WORD_W-1:0] mem_q [2**ADDR_W];
	logic              busy_q;    // request seen, delay running
	logic [1:0]        delay_q;
	integer            seed;

	function automatic lease_word_u entry_word(input logic [TAG_W-1:0] tag,
	                                           input logic [LEASE_W-1:0] lease);
		lease_word_u w;
		w           = '0;
		w.ent.valid = 1'b1;
		w.ent.lease = lease;
		w.ent.tag   = tag;
		return w;
	endfunction

	// image and lease tables
	// --------------------------------------------------
	initial begin
		lease_word_u hdr;
		seed        = 71;
		ack_o       = 1'b0;
		rdata_o     = '0;
		txn_count_o = 0;
		for (int a = 0; a < 2**ADDR_W; a++)
			mem_q[a] = {16'(a) ^ 16'hC35A, 16'(a)};   // whole address in every word
		hdr           = '0;
		hdr.hdr.count = COUNT_W'(P0_COUNT);
		mem_q[TABLE_BASE] = hdr;
		for (int i = 0; i < P0_COUNT; i++)
			mem_q[TABLE_BASE + 1 + i] = (i == 0) ? entry_word(BYP0_TAG, 8'd0) :
			                            (i == 1) ? entry_word(BYP1_TAG, 8'd5) :
			                            entry_word(TAG_W'(14'h3F00 + i), 8'd2);
		hdr.hdr.count = COUNT_W'(P1_COUNT);
		mem_q[TABLE_BASE + TABLE_STRIDE] = hdr;
		for (int i = 0; i < P1_COUNT; i++)
			mem_q[TABLE_BASE + TABLE_STRIDE + 1 + i] = (i == 0) ? entry_word(BYP1_TAG, 8'd0) :
			                                           (i == 1) ? entry_word(BYP0_TAG, 8'd3) :
			                                           entry_word(TAG_W'(14'h3F10 + i), 8'd1);
	end

	// four-phase responder
	// --------------------------------------------------
	always @(posedge clock_i) begin
		if (!resetn_i) begin
			ack_o       <= 1'b0;
			busy_q      <= 1'b0;
			delay_q     <= '0;
			txn_count_o <= 0;
		end else if (ack_o) begin
			if (!req_i)
				ack_o <= 1'b0;                      // requester let go
		end else if (req_i) begin
			if (!busy_q) begin
				busy_q  <= 1'b1;
				delay_q <= 2'($random(seed));       // 0..3 extra cycles
			end else if (delay_q != '0) begin
				delay_q <= delay_q - 1'b1;
			end else begin
				busy_q      <= 1'b0;
				ack_o       <= 1'b1;
				txn_count_o <= txn_count_o + 1;
				if (cmd_i.rw)
					mem_q[cmd_i.addr] <= cmd_i.wdata;
				else
					rdata_o <= mem_q[cmd_i.addr];
			end
		end
	end

endmodule

`default_nettype wire

//--- src/lease_cache_top.sv
`timescale 1ns/100ps
`default_nettype none

module lease_cache_top import lease_cache_pkg::*; #(
	parameter int                 LINES         = 4,
	parameter logic [LEASE_W-1:0] DEFAULT_LEASE = 4,
	localparam int                LINE_W        = $clog2(LINES)
) (
	input  wire               clock_i,
	input  wire               resetn_i,
	input  wire  [7:0]        phase_i,
	input  wire               core_req_i,
	input  wire core_req_t    core_cmd_i,
	output logic              core_ack_o,
	output logic [WORD_W-1:0] core_rdata_o,
	output logic              mem_req_o,
	output mem_cmd_t          mem_cmd_o,
	input  wire               mem_ack_i,
	input  wire  [WORD_W-1:0] mem_rdata_i
);

	// loader side
	logic                   loading, idle;
	logic                   table_clear, table_wr;
	logic [TABLE_IDX_W-1:0] table_idx;
	lease_word_u            table_word;
	logic                   ld_req, ld_ack;
	mem_cmd_t               ld_cmd;
	logic [WORD_W-1:0]      ld_rdata;

	// miss handler side
	logic                   mh_req, mh_ack;
	mem_cmd_t               mh_cmd;
	logic [WORD_W-1:0]      mh_rdata;
	logic [TAG_W-1:0]       match_tag, install_tag, line_tag, lookup_tag;
	logic                   hit, wr, install, touch;
	logic [LINE_W-1:0]      hit_line, rd_line, wr_line, install_line, touch_line, victim_line;
	logic [OFFSET_W-1:0]    rd_word, wr_word;
	logic [WORD_W-1:0]      rdata, wdata;
	logic [LEASE_W-1:0]     lease, touch_lease;

	line_store #(.LINES(LINES)) u_store (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.match_tag_i    (match_tag),
		.hit_o          (hit),
		.hit_line_o     (hit_line),
		.rd_line_i      (rd_line),
		.rd_word_i      (rd_word),
		.rdata_o        (rdata),
		.wr_i           (wr),
		.wr_line_i      (wr_line),
		.wr_word_i      (wr_word),
		.wdata_i        (wdata),
		.install_i      (install),
		.install_line_i (install_line),
		.install_tag_i  (install_tag),
		.line_tag_o     (line_tag)
	);

	lease_policy #(.LINES(LINES), .DEFAULT_LEASE(DEFAULT_LEASE)) u_policy (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.table_wr_i    (table_wr),
		.table_idx_i   (table_idx),
		.table_word_i  (table_word),
		.table_clear_i (table_clear),
		.lookup_tag_i  (lookup_tag),
		.lease_o       (lease),
		.touch_i       (touch),
		.touch_line_i  (touch_line),
		.touch_lease_i (touch_lease),
		.victim_line_o (victim_line)
	);

	lease_table_loader u_loader (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.phase_i       (phase_i),
		.idle_i        (idle),
		.loading_o     (loading),
		.table_clear_o (table_clear),
		.table_wr_o    (table_wr),
		.table_idx_o   (table_idx),
		.table_word_o  (table_word),
		.mreq_o        (ld_req),
		.mcmd_o        (ld_cmd),
		.mack_i        (ld_ack),
		.mrdata_i      (ld_rdata)
	);

	miss_handler #(.LINES(LINES)) u_handler (
		.clock_i        (clock_i),
		.resetn_i       (resetn_i),
		.core_req_i     (core_req_i),
		.core_cmd_i     (core_cmd_i),
		.core_ack_o     (core_ack_o),
		.core_rdata_o   (core_rdata_o),
		.loading_i      (loading),
		.idle_o         (idle),
		.match_tag_o    (match_tag),
		.hit_i          (hit),
		.hit_line_i     (hit_line),
		.rd_line_o      (rd_line),
		.rd_word_o      (rd_word),
		.rdata_i        (rdata),
		.wr_o           (wr),
		.wr_line_o      (wr_line),
		.wr_word_o      (wr_word),
		.wdata_o        (wdata),
		.install_o      (install),
		.install_line_o (install_line),
		.install_tag_o  (install_tag),
		.line_tag_i     (line_tag),
		.lookup_tag_o   (lookup_tag),
		.lease_i        (lease),
		.touch_o        (touch),
		.touch_line_o   (touch_line),
		.touch_lease_o  (touch_lease),
		.victim_line_i  (victim_line),
		.mreq_o         (mh_req),
		.mcmd_o         (mh_cmd),
		.mack_i         (mh_ack),
		.mrdata_i       (mh_rdata)
	);

	// loader is peer a
	mem_arbiter u_arb (
		.clock_i     (clock_i),
		.resetn_i    (resetn_i),
		.a_req_i     (ld_req),
		.a_cmd_i     (ld_cmd),
		.a_ack_o     (ld_ack),
		.a_rdata_o   (ld_rdata),
		.b_req_i     (mh_req),
		.b_cmd_i     (mh_cmd),
		.b_ack_o     (mh_ack),
		.b_rdata_o   (mh_rdata),
		.mem_req_o   (mem_req_o),
		.mem_cmd_o   (mem_cmd_o),
		.mem_ack_i   (mem_ack_i),
		.mem_rdata_i (mem_rdata_i)
	);

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import lease_cache_pkg::*; (
	input  wire               clock_i,
	input  wire               resetn_i,
	input  wire               a_req_i,
	input  wire mem_cmd_t     a_cmd_i,
	output logic              a_ack_o,
	output logic [WORD_W-1:0] a_rdata_o,
	input  wire               b_req_i,
	input  wire mem_cmd_t     b_cmd_i,
	output logic              b_ack_o,
	output logic [WORD_W-1:0] b_rdata_o,
	output logic              mem_req_o,
	output mem_cmd_t          mem_cmd_o,
	input  wire               mem_ack_i,
	input  wire  [WORD_W-1:0] mem_rdata_i
);

	logic gnt_q;     // port is owned
	logic gnt_b_q;   // owner, 1: b
	logic own_req;

	assign own_req = gnt_b_q ? b_req_i : a_req_i;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			gnt_q   <= 1'b0;
			gnt_b_q <= 1'b0;
		end else if (!gnt_q) begin
			if (a_req_i || b_req_i) begin
				gnt_q   <= 1'b1;
				gnt_b_q <= !a_req_i;                 // loader wins a tie
			end
		end else if (!own_req && !mem_ack_i) begin
			gnt_q <= 1'b0;                           // handshake fully closed
		end
	end

	assign mem_req_o = gnt_q && own_req;
	assign mem_cmd_o = gnt_b_q ? b_cmd_i : a_cmd_i;
	assign a_ack_o   = gnt_q && !gnt_b_q && mem_ack_i;
	assign b_ack_o   = gnt_q && gnt_b_q && mem_ack_i;
	assign a_rdata_o = mem_rdata_i;
	assign b_rdata_o = mem_rdata_i;

	// memory acks only inside a granted transfer
	assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_ack_i |-> gnt_q && $past(gnt_q));

endmodule

`default_nettype wire

//--- src/miss_handler.sv
`timescale 1ns/100ps
`default_nettype none

module miss_handler import lease_cache_pkg::*; #(
	parameter int  LINES  = 4,
	localparam int LINE_W = $clog2(LINES)
) (
	input  wire                 clock_i,
	input  wire                 resetn_i,
	input  wire                 core_req_i,
	input  wire core_req_t      core_cmd_i,
	output logic                core_ack_o,
	output logic [WORD_W-1:0]   core_rdata_o,
	input  wire                 loading_i,
	output logic                idle_o,
	// line store
	output logic [TAG_W-1:0]    match_tag_o,
	input  wire                 hit_i,
	input  wire  [LINE_W-1:0]   hit_line_i,
	output logic [LINE_W-1:0]   rd_line_o,
	output logic [OFFSET_W-1:0] rd_word_o,
	input  wire  [WORD_W-1:0]   rdata_i,
	output logic                wr_o,
	output logic [LINE_W-1:0]   wr_line_o,
	output logic [OFFSET_W-1:0] wr_word_o,
	output logic [WORD_W-1:0]   wdata_o,
	output logic                install_o,
	output logic [LINE_W-1:0]   install_line_o,
	output logic [TAG_W-1:0]    install_tag_o,
	input  wire  [TAG_W-1:0]    line_tag_i,
	// policy
	output logic [TAG_W-1:0]    lookup_tag_o,
	input  wire  [LEASE_W-1:0]  lease_i,
	output logic                touch_o,
	output logic [LINE_W-1:0]   touch_line_o,
	output logic [LEASE_W-1:0]  touch_lease_o,
	input  wire  [LINE_W-1:0]   victim_line_i,
	// memory
	output logic                mreq_o,
	output mem_cmd_t            mcmd_o,
	input  wire                 mack_i,
	input  wire  [WORD_W-1:0]   mrdata_i
);

	typedef enum logic [2:0] {S_IDLE, S_LOOKUP, S_EVICT, S_MREQ, S_MREL, S_DONE} state_t;
	typedef enum logic [1:0] {M_BYP, M_WB, M_FILL} mode_t;

	state_t              state_q;
	mode_t               mode_q;
	core_req_t           cmd_q;
	logic [LINE_W-1:0]   line_q;     // victim being replaced
	logic [LINE_W-1:0]   cur_line;
	logic [OFFSET_W-1:0] word_q;
	logic [OFFSET_W-1:0] nxt_word;
	logic [LINES-1:0]    dirty_q;
	logic [TAG_W-1:0]    req_tag;
	logic [OFFSET_W-1:0] req_word;
	logic                in_lookup;
	logic                last_word;
	mem_cmd_t            wb_cmd;
	mem_cmd_t            fill_cmd;

	assign req_tag   = cmd_q.addr[ADDR_W-1:OFFSET_W];
	assign req_word  = cmd_q.addr[OFFSET_W-1:0];
	assign in_lookup = (state_q == S_LOOKUP);
	assign nxt_word  = word_q + 1'b1;
	assign last_word = &word_q;
	assign idle_o    = (state_q == S_IDLE);

	// array and policy hookup
	// --------------------------------------------------
	assign cur_line     = in_lookup ? hit_line_i : line_q;
	assign match_tag_o  = req_tag;
	assign lookup_tag_o = req_tag;
	assign rd_line_o    = cur_line;
	assign rd_word_o    = in_lookup ? req_word : (state_q == S_MREL) ? nxt_word : word_q;
	assign wr_line_o    = cur_line;
	assign wr_word_o    = in_lookup ? req_word : word_q;
	assign wdata_o      = in_lookup ? cmd_q.wdata : mrdata_i;
	assign wr_o         = (in_lookup && hit_i && cmd_q.rw) ||
	                      ((state_q == S_MREQ) && (mode_q == M_FILL) && mack_i);
	assign install_o      = (state_q == S_MREL) && (mode_q == M_FILL) && last_word && !mack_i;
	assign install_line_o = line_q;
	assign install_tag_o  = req_tag;
	assign touch_o        = in_lookup && hit_i;   // a fill comes back here as a hit
	assign touch_line_o   = hit_line_i;
	assign touch_lease_o  = lease_i;

	// word at rd_word_o, old tag still in place
	assign wb_cmd   = '{rw: 1'b1, addr: {line_tag_i, rd_word_o}, wdata: rdata_i};
	assign fill_cmd = '{rw: 1'b0, addr: {req_tag, rd_word_o}, wdata: '0};

	// control
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q    <= S_IDLE;
			mode_q     <= M_BYP;
			word_q     <= '0;
			dirty_q    <= '0;
			core_ack_o <= 1'b0;
			mreq_o     <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: if (core_req_i && !loading_i)
					state_q <= S_LOOKUP;
				S_LOOKUP: begin
					word_q <= '0;
					if (hit_i) begin
						if (cmd_q.rw)
							dirty_q[hit_line_i] <= 1'b1;
						core_ack_o <= 1'b1;
						state_q    <= S_DONE;
					end else if (lease_i == '0) begin
						mode_q  <= M_BYP;            // not cacheable, one word only
						mreq_o  <= 1'b1;
						state_q <= S_MREQ;
					end else begin
						state_q <= S_EVICT;
					end
				end
				S_EVICT: begin
					mode_q  <= dirty_q[line_q] ? M_WB : M_FILL;
					mreq_o  <= 1'b1;
					state_q <= S_MREQ;
				end
				S_MREQ: if (mack_i) begin
					mreq_o  <= 1'b0;
					state_q <= S_MREL;
				end
				S_MREL: if (!mack_i) begin
					word_q <= nxt_word;
					case (mode_q)
						M_BYP: begin
							core_ack_o <= 1'b1;
							state_q    <= S_DONE;
						end
						M_WB: begin
							mreq_o  <= 1'b1;
							state_q <= S_MREQ;
							if (last_word) begin
								dirty_q[line_q] <= 1'b0;
								mode_q          <= M_FILL;
							end
						end
						default: if (last_word) begin
							state_q <= S_LOOKUP;     // tag installed, hits now
						end else begin
							mreq_o  <= 1'b1;
							state_q <= S_MREQ;
						end
					endcase
				end
				S_DONE: if (!core_req_i) begin
					core_ack_o <= 1'b0;
					state_q    <= S_IDLE;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// payload
	always_ff @(posedge clock_i) begin
		case (state_q)
			S_IDLE: cmd_q <= core_cmd_i;
			S_LOOKUP: begin
				line_q       <= victim_line_i;
				core_rdata_o <= rdata_i;             // hit word
				mcmd_o       <= '{rw: cmd_q.rw, addr: cmd_q.addr, wdata: cmd_q.wdata};
			end
			S_EVICT: mcmd_o <= dirty_q[line_q] ? wb_cmd : fill_cmd;
			S_MREQ: if (mack_i && (mode_q == M_BYP) && !cmd_q.rw)
				core_rdata_o <= mrdata_i;
			S_MREL: mcmd_o <= ((mode_q == M_WB) && !last_word) ? wb_cmd : fill_cmd;
			default: ;
		endcase
	end

	// ack only answers a live request
	assert property (@(posedge clock_i) disable iff (!resetn_i)
		$rose(core_ack_o) |-> core_req_i);

endmodule

`default_nettype wire

//--- src/lease_table_loader.sv
`timescale 1ns/100ps
`default_nettype none

module lease_table_loader import lease_cache_pkg::*; (
	input  wire                    clock_i,
	input  wire                    resetn_i,
	input  wire  [7:0]             phase_i,
	input  wire                    idle_i,
	output logic                   loading_o,
	output logic                   table_clear_o,
	output logic                   table_wr_o,
	output logic [TABLE_IDX_W-1:0] table_idx_o,
	output lease_word_u            table_word_o,
	output logic                   mreq_o,
	output mem_cmd_t               mcmd_o,
	input  wire                    mack_i,
	input  wire  [WORD_W-1:0]      mrdata_i
);

	typedef enum logic [1:0] {L_IDLE, L_REQ, L_REL} lstate_t;

	lstate_t            state_q;
	logic [7:0]         phase_q;
	logic               boot_q;       // phase 0 table still owed after reset
	logic [ADDR_W-1:0]  base_q;
	logic [ADDR_W-1:0]  phase_base;
	logic [COUNT_W-1:0] word_cnt_q;   // header + entries read so far
	logic [COUNT_W-1:0] n_ent_q;
	lease_word_u        rd_word;
	logic               reload_due;

	assign rd_word    = mrdata_i;
	assign phase_base = TABLE_BASE + ADDR_W'(phase_i * TABLE_STRIDE);
	assign reload_due = boot_q || (phase_q != phase_i);
	assign loading_o  = reload_due || (state_q != L_IDLE);   // holds off new core requests

	// control
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q       <= L_IDLE;
			phase_q       <= '0;
			boot_q        <= 1'b1;
			word_cnt_q    <= '0;
			n_ent_q       <= '0;
			mreq_o        <= 1'b0;
			table_clear_o <= 1'b0;
			table_wr_o    <= 1'b0;
		end else begin
			table_clear_o <= 1'b0;
			table_wr_o    <= 1'b0;
			case (state_q)
				L_IDLE: if (reload_due && idle_i) begin
					phase_q       <= phase_i;
					boot_q        <= 1'b0;
					table_clear_o <= 1'b1;
					word_cnt_q    <= '0;
					mreq_o        <= 1'b1;           // header read
					state_q       <= L_REQ;
				end
				L_REQ: if (mack_i) begin
					if (word_cnt_q == '0) begin
						// cap at table size
						if (rd_word.hdr.count > COUNT_W'(TABLE_ENTRIES))
							n_ent_q <= COUNT_W'(TABLE_ENTRIES);
						else
							n_ent_q <= rd_word.hdr.count;
					end else begin
						table_wr_o <= 1'b1;
					end
					word_cnt_q <= word_cnt_q + 1'b1;
					mreq_o     <= 1'b0;
					state_q    <= L_REL;
				end
				L_REL: if (!mack_i) begin
					if (word_cnt_q > n_ent_q) begin
						state_q <= L_IDLE;           // all entries in
					end else begin
						mreq_o  <= 1'b1;
						state_q <= L_REQ;
					end
				end
				default: state_q <= L_IDLE;
			endcase
		end
	end

	// payload
	always_ff @(posedge clock_i) begin
		if (state_q == L_IDLE) begin
			base_q <= phase_base;
			mcmd_o <= '{rw: 1'b0, addr: phase_base, wdata: '0};
		end else if (state_q == L_REL) begin
			mcmd_o.addr <= base_q + ADDR_W'(word_cnt_q);
		end
		if ((state_q == L_REQ) && mack_i) begin
			table_idx_o  <= TABLE_IDX_W'(word_cnt_q - 1'b1);
			table_word_o <= rd_word;
		end
	end

	// command holds for the whole handshake
	assert property (@(posedge clock_i) disable iff (!resetn_i)
		mreq_o && $past(mreq_o) |-> $stable(mcmd_o));

endmodule

`default_nettype wire

//--- src/lease_policy.sv
`timescale 1ns/100ps
`default_nettype none

module lease_policy import lease_cache_pkg::*; #(
	parameter int                 LINES         = 4,
	parameter logic [LEASE_W-1:0] DEFAULT_LEASE = 4,
	localparam int                LINE_W        = $clog2(LINES)
) (
	input  wire                    clock_i,
	input  wire                    resetn_i,
	input  wire                    table_wr_i,
	input  wire  [TABLE_IDX_W-1:0] table_idx_i,
	input  wire lease_word_u       table_word_i,
	input  wire                    table_clear_i,
	input  wire  [TAG_W-1:0]       lookup_tag_i,
	output logic [LEASE_W-1:0]     lease_o,
	input  wire                    touch_i,
	input  wire  [LINE_W-1:0]      touch_line_i,
	input  wire  [LEASE_W-1:0]     touch_lease_i,
	output logic [LINE_W-1:0]      victim_line_o
);

	logic [TAG_W-1:0]         tbl_tag   [TABLE_ENTRIES];
	logic [LEASE_W-1:0]       tbl_lease [TABLE_ENTRIES];
	logic [TABLE_ENTRIES-1:0] tbl_valid;
	logic [LEASE_W-1:0]       cnt_q     [LINES];   // remaining lease per line
	logic [LINE_W-1:0]        rr_q;                // fallback victim
	logic [LINE_W-1:0]        zero_line;
	logic                     any_zero;

	// lease table
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			tbl_valid <= '0;
		else if (table_clear_i)
			tbl_valid <= '0;                         // new phase
		else if (table_wr_i)
			tbl_valid[table_idx_i] <= table_word_i.ent.valid;
	end

	always_ff @(posedge clock_i) begin
		if (table_wr_i) begin
			tbl_tag[table_idx_i]   <= table_word_i.ent.tag;
			tbl_lease[table_idx_i] <= table_word_i.ent.lease;
		end
	end

	// blocks not in the table get the default lease
	always_comb begin
		lease_o = DEFAULT_LEASE;
		for (int i = 0; i < TABLE_ENTRIES; i++) begin
			if (tbl_valid[i] && (tbl_tag[i] == lookup_tag_i))
				lease_o = tbl_lease[i];
		end
	end

	// victim choice
	// --------------------------------------------------
	always_comb begin
		any_zero  = 1'b0;
		zero_line = '0;
		for (int i = LINES - 1; i >= 0; i--) begin   // lowest expired line wins
			if (cnt_q[i] == '0) begin
				any_zero  = 1'b1;
				zero_line = LINE_W'(i);
			end
		end
	end

	assign victim_line_o = any_zero ? zero_line : rr_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			rr_q <= '0;
			for (int i = 0; i < LINES; i++)
				cnt_q[i] <= '0;                      // invalid lines look expired
		end else if (touch_i) begin
			for (int i = 0; i < LINES; i++) begin
				if (cnt_q[i] != '0)
					cnt_q[i] <= cnt_q[i] - 1'b1;     // age every live line
			end
			cnt_q[touch_line_i] <= touch_lease_i;    // then renew the touched one
			// fill into the pointer's line moves it on
			if (!any_zero && (touch_line_i == rr_q))
				rr_q <= (rr_q == LINE_W'(LINES - 1)) ? '0 : rr_q + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/line_store.sv
`timescale 1ns/100ps
`default_nettype none

module line_store import lease_cache_pkg::*; #(
	parameter int  LINES  = 4,
	localparam int LINE_W = $clog2(LINES)
) (
	input  wire                 clock_i,
	input  wire                 resetn_i,
	input  wire  [TAG_W-1:0]    match_tag_i,
	output logic                hit_o,
	output logic [LINE_W-1:0]   hit_line_o,
	input  wire  [LINE_W-1:0]   rd_line_i,
	input  wire  [OFFSET_W-1:0] rd_word_i,
	output logic [WORD_W-1:0]   rdata_o,
	input  wire                 wr_i,
	input  wire  [LINE_W-1:0]   wr_line_i,
	input  wire  [OFFSET_W-1:0] wr_word_i,
	input  wire  [WORD_W-1:0]   wdata_i,
	input  wire                 install_i,
	input  wire  [LINE_W-1:0]   install_line_i,
	input  wire  [TAG_W-1:0]    install_tag_i,
	output logic [TAG_W-1:0]    line_tag_o
);

	logic [TAG_W-1:0]  tag_q  [LINES];
	logic [WORD_W-1:0] data_q [LINES][WORDS_PER_BLOCK];
	logic [LINES-1:0]  valid_q;
	logic [LINES-1:0]  match_vec;

	// fully associative compare
	always_comb begin
		hit_line_o = '0;
		for (int i = 0; i < LINES; i++) begin
			match_vec[i] = valid_q[i] && (tag_q[i] == match_tag_i);
			if (match_vec[i])
				hit_line_o = LINE_W'(i);
		end
	end

	assign hit_o      = |match_vec;
	assign rdata_o    = data_q[rd_line_i][rd_word_i];
	assign line_tag_o = tag_q[rd_line_i];    // write-back address

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			valid_q <= '0;
		else if (install_i)
			valid_q[install_line_i] <= 1'b1;
	end

	always_ff @(posedge clock_i) begin
		if (install_i)
			tag_q[install_line_i] <= install_tag_i;
		if (wr_i)
			data_q[wr_line_i][wr_word_i] <= wdata_i;
	end

	// a fill never installs a block that is already resident
	assert property (@(posedge clock_i) disable iff (!resetn_i) $onehot0(match_vec));

endmodule

`default_nettype wire

//--- src/lease_cache_pkg.sv
`default_nettype none

package lease_cache_pkg;

	// address layout
	// --------------------------------------------------
	localparam int ADDR_W          = 16;
	localparam int WORD_W          = 32;
	localparam int OFFSET_W        = 2;                 // 4 words per block
	localparam int WORDS_PER_BLOCK = 1 << OFFSET_W;
	localparam int TAG_W           = ADDR_W - OFFSET_W; // block address
	localparam int LEASE_W         = 8;

	// lease table in external memory
	// --------------------------------------------------
	localparam int                TABLE_ENTRIES = 8;
	localparam int                TABLE_IDX_W   = $clog2(TABLE_ENTRIES);
	localparam int                COUNT_W       = TABLE_IDX_W + 1; // 0 .. TABLE_ENTRIES
	localparam logic [ADDR_W-1:0] TABLE_BASE    = 16'h8000;        // phase 0 header
	localparam int                TABLE_STRIDE  = 16;              // words per phase

	typedef struct packed {
		logic              rw;    // 1: write
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
	} mem_cmd_t;

	typedef struct packed {
		logic              rw;    // 1: store
		logic [ADDR_W-1:0] addr;
		logic [WORD_W-1:0] wdata;
	} core_req_t;

	// word 0 of a table
	typedef struct packed {
		logic [WORD_W-COUNT_W-1:0] rsvd;
		logic [COUNT_W-1:0]        count;  // entries that follow
	} lease_hdr_t;

	// words 1 .. count
	typedef struct packed {
		logic                              valid;
		logic [WORD_W-1-LEASE_W-TAG_W-1:0] rsvd;
		logic [LEASE_W-1:0]                lease;
		logic [TAG_W-1:0]                  tag;
	} lease_ent_t;

	typedef union packed {
		lease_hdr_t hdr;
		lease_ent_t ent;
	} lease_word_u;

endpackage

`default_nettype wire
